//--- rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

  localparam int xlen = 32;
  localparam int strb_w = xlen / 8;
  localparam int reg_aw = 5;
  localparam int num_regs = 1 << reg_aw;
  localparam logic [xlen-1:0] reset_pc = '0;
  localparam logic [31:0] ebreak_inst = 32'h0010_0073;

  typedef enum logic [6:0] {
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_branch = 7'b1100011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_op_imm = 7'b0010011,
    opc_op     = 7'b0110011,
    opc_system = 7'b1110011
  } opcode_e;

  // Encoded as {funct7[5], funct3} so decode can build it directly
  typedef enum logic [3:0] {
    alu_add  = 4'b0000,
    alu_sll  = 4'b0001,
    alu_slt  = 4'b0010,
    alu_sltu = 4'b0011,
    alu_xor  = 4'b0100,
    alu_srl  = 4'b0101,
    alu_or   = 4'b0110,
    alu_and  = 4'b0111,
    alu_sub  = 4'b1000,
    alu_sra  = 4'b1101
  } alu_op_e;

  typedef enum logic [2:0] {
    br_beq  = 3'b000,
    br_bne  = 3'b001,
    br_none = 3'b010, // Free funct3 slot
    br_blt  = 3'b100,
    br_bge  = 3'b101,
    br_bltu = 3'b110,
    br_bgeu = 3'b111
  } branch_op_e;

  typedef enum logic [1:0] {
    res_alu,
    res_mem,
    res_link
  } result_sel_e;

  typedef struct packed {
    logic [reg_aw-1:0] rs1;
    logic [reg_aw-1:0] rs2;
    logic [reg_aw-1:0] rd;
    logic [xlen-1:0]   imm;
    alu_op_e           alu_op;
    branch_op_e        branch_op;
    result_sel_e       result_sel;
    logic              src2_imm;
    logic              src1_pc;
    logic              jump;
    logic              jump_reg;
    logic              load;
    logic              store;
    logic              reg_write;
    logic              halt;
    logic              illegal;
  } decoded_t;

  typedef struct packed {
    logic [xlen-1:0]   addr;
    logic [xlen-1:0]   wdata;
    logic [strb_w-1:0] strb;
    logic              write;
  } mem_req_t;

  typedef struct packed {
    logic [xlen-1:0] rdata;
    logic            err;
  } mem_rsp_t;

endpackage

`default_nettype wire

//--- rv_fetch.sv
`default_nettype none

module rv_fetch (
  input  logic                          clock,
  input  logic                          rst,
  input  logic                          retire,
  input  logic [rv_core_pkg::xlen-1:0]  next_pc,
  output logic                          req_valid,
  output rv_core_pkg::mem_req_t         req,
  input  logic                          req_ready,
  input  logic                          rsp_valid,
  input  rv_core_pkg::mem_rsp_t         rsp,
  input  logic                          halted,
  output logic [rv_core_pkg::xlen-1:0]  inst,
  output logic [rv_core_pkg::xlen-1:0]  pc,
  output logic                          inst_valid
);
  import rv_core_pkg::*;

  typedef enum logic [1:0] {f_idle, f_req, f_wait, f_hold} fetch_state_e;

  fetch_state_e state;

  assign req_valid = state == f_req && !halted; // Halt stops the refetch after retire
  assign req = '{addr: pc, wdata: '0, strb: '0, write: 1'b0};
  assign inst_valid = state == f_hold;

  always_ff @(posedge clock) begin
    if (rst) begin
      state <= f_idle;
      pc <= reset_pc;
    end else begin
      case (state)
        f_idle: state <= f_req;
        f_req: if (req_valid && req_ready) state <= f_wait;
        f_wait: if (rsp_valid) state <= f_hold;
        default: begin
          if (retire) begin
            state <= f_req;
            pc <= next_pc;
          end
        end
      endcase
    end
  end

  // A bus error fetches an all-zero word, which decodes as illegal
  always_ff @(posedge clock) begin
    if (state == f_wait && rsp_valid) inst <= rsp.err ? '0 : rsp.rdata;
  end

  assert property (@(posedge clock) disable iff (rst)
    req_valid && !req_ready |=> req_valid && $stable(req));

endmodule

`default_nettype wire

//--- rv_decode.sv
`default_nettype none

module rv_decode (
  input  logic [rv_core_pkg::xlen-1:0] inst,
  output rv_core_pkg::decoded_t        dec
);
  import rv_core_pkg::*;

  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [xlen-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    dec = '0;
    dec.rs1 = inst[19:15];
    dec.rs2 = inst[24:20];
    dec.rd = inst[11:7];
    dec.alu_op = alu_add;
    dec.branch_op = br_none;
    dec.result_sel = res_alu;
    case (opcode_e'(inst[6:0]))
      opc_lui: begin
        dec.rs1 = '0; // x0 + imm
        dec.imm = imm_u;
        dec.src2_imm = 1'b1;
        dec.reg_write = 1'b1;
      end
      opc_auipc, opc_jal: begin
        dec.imm = inst[2] && inst[3] ? imm_j : imm_u;
        dec.src1_pc = 1'b1;
        dec.src2_imm = 1'b1;
        dec.jump = inst[3];
        dec.reg_write = 1'b1;
        dec.result_sel = inst[3] ? res_link : res_alu;
      end
      opc_jalr: begin
        dec.imm = imm_i;
        dec.src2_imm = 1'b1;
        dec.jump = 1'b1;
        dec.jump_reg = 1'b1;
        dec.reg_write = 1'b1;
        dec.result_sel = res_link;
        dec.illegal = funct3 != 3'b000;
      end
      opc_branch: begin
        dec.imm = imm_b;
        dec.branch_op = funct3[2:1] == 2'b01 ? br_none : branch_op_e'(funct3);
        dec.illegal = funct3[2:1] == 2'b01;
      end
      opc_load, opc_store: begin
        dec.imm = inst[5] ? imm_s : imm_i;
        dec.src2_imm = 1'b1;
        dec.load = !inst[5];
        dec.store = inst[5];
        dec.reg_write = !inst[5];
        dec.result_sel = res_mem;
        dec.illegal = funct3 != 3'b010; // Word access only
      end
      opc_op_imm: begin
        dec.imm = imm_i;
        dec.src2_imm = 1'b1;
        dec.reg_write = 1'b1;
        dec.alu_op = alu_op_e'({funct3 == 3'b101 && inst[30], funct3});
        dec.illegal = (funct3 == 3'b001 && funct7 != '0) ||
                      (funct3 == 3'b101 && (funct7 & 7'b1011111) != '0);
      end
      opc_op: begin
        dec.reg_write = 1'b1;
        dec.alu_op = alu_op_e'({inst[30], funct3});
        dec.illegal = (funct7 & 7'b1011111) != '0 ||
                      (inst[30] && funct3 != 3'b000 && funct3 != 3'b101);
      end
      opc_system: begin
        dec.halt = inst == ebreak_inst;
        dec.illegal = inst != ebreak_inst;
      end
      default: dec.illegal = 1'b1;
    endcase
    if (dec.illegal) begin
      dec.reg_write = 1'b0;
      dec.load = 1'b0;
      dec.store = 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- rv_regfile.sv
`default_nettype none

module rv_regfile (
  input  logic                            clock,
  input  logic                            rst,
  input  logic [rv_core_pkg::reg_aw-1:0]  raddr1,
  input  logic [rv_core_pkg::reg_aw-1:0]  raddr2,
  output logic [rv_core_pkg::xlen-1:0]    rdata1,
  output logic [rv_core_pkg::xlen-1:0]    rdata2,
  input  logic                            wen,
  input  logic [rv_core_pkg::reg_aw-1:0]  waddr,
  input  logic [rv_core_pkg::xlen-1:0]    wdata
);
  import rv_core_pkg::*;

  logic [xlen-1:0] regs [num_regs];

  always_ff @(posedge clock) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && waddr != '0) begin // x0 keeps its reset zero
      regs[waddr] <= wdata;
    end
  end

  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];

endmodule

`default_nettype wire

//--- rv_execute.sv
`default_nettype none

module rv_execute (
  input  rv_core_pkg::decoded_t         dec,
  input  logic [rv_core_pkg::xlen-1:0]  pc,
  input  logic [rv_core_pkg::xlen-1:0]  src1,
  input  logic [rv_core_pkg::xlen-1:0]  src2,
  output logic [rv_core_pkg::xlen-1:0]  alu_result,
  output logic [rv_core_pkg::xlen-1:0]  link_addr,
  output logic                          branch_taken,
  output logic [rv_core_pkg::xlen-1:0]  next_pc
);
  import rv_core_pkg::*;

  logic [xlen-1:0] op_a, op_b, target;
  logic [4:0] shamt;
  logic cond;

  assign op_a = dec.src1_pc ? pc : src1;
  assign op_b = dec.src2_imm ? dec.imm : src2;
  assign shamt = op_b[4:0];

  always_comb begin
    case (dec.alu_op)
      alu_add: alu_result = op_a + op_b;
      alu_sub: alu_result = op_a - op_b;
      alu_sll: alu_result = op_a << shamt;
      alu_slt: alu_result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      alu_sltu: alu_result = {{(xlen-1){1'b0}}, op_a < op_b};
      alu_xor: alu_result = op_a ^ op_b;
      alu_srl: alu_result = op_a >> shamt;
      alu_sra: alu_result = $signed(op_a) >>> shamt;
      alu_or: alu_result = op_a | op_b;
      alu_and: alu_result = op_a & op_b;
      default: alu_result = '0;
    endcase
  end

  // Branch compare always uses the register operands
  always_comb begin
    case (dec.branch_op)
      br_beq: cond = src1 == src2;
      br_bne: cond = src1 != src2;
      br_blt: cond = $signed(src1) < $signed(src2);
      br_bge: cond = $signed(src1) >= $signed(src2);
      br_bltu: cond = src1 < src2;
      br_bgeu: cond = src1 >= src2;
      default: cond = 1'b0;
    endcase
  end

  assign branch_taken = cond || dec.jump;
  assign link_addr = pc + xlen'(4);
  assign target = dec.jump_reg ? {alu_result[xlen-1:1], 1'b0} : pc + dec.imm;
  assign next_pc = branch_taken ? target : link_addr;

endmodule

`default_nettype wire

//--- rv_lsu.sv
`default_nettype none

module rv_lsu (
  input  logic                          clock,
  input  logic                          rst,
  input  logic                          start,
  input  rv_core_pkg::decoded_t         dec,
  input  logic [rv_core_pkg::xlen-1:0]  addr,
  input  logic [rv_core_pkg::xlen-1:0]  store_data,
  output logic                          req_valid,
  output rv_core_pkg::mem_req_t         req,
  input  logic                          req_ready,
  input  logic                          rsp_valid,
  input  rv_core_pkg::mem_rsp_t         rsp,
  output logic [rv_core_pkg::xlen-1:0]  load_data,
  output logic                          lsu_done
);
  import rv_core_pkg::*;

  typedef enum logic [1:0] {ls_idle, ls_req, ls_wait} lsu_state_e;

  lsu_state_e state;

  assign req_valid = state == ls_req;
  // Operands are held by decode until retire, so the request stays stable
  assign req = '{addr: addr, wdata: store_data, strb: {strb_w{dec.store}}, write: dec.store};

  always_ff @(posedge clock) begin
    if (rst) begin
      state <= ls_idle;
      lsu_done <= 1'b0;
    end else begin
      lsu_done <= 1'b0;
      case (state)
        ls_idle: if (start) state <= ls_req;
        ls_req: if (req_ready) state <= ls_wait;
        default: begin
          if (rsp_valid) begin
            state <= ls_idle;
            lsu_done <= 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == ls_wait && rsp_valid) load_data <= rsp.rdata;
  end

  // A response reaches the LSU only for its own accepted request
  assert property (@(posedge clock) disable iff (rst) rsp_valid |-> state == ls_wait);

endmodule

`default_nettype wire

//--- rv_bus_arbiter.sv
`default_nettype none

module rv_bus_arbiter (
  input  logic                   clock,
  input  logic                   rst,
  input  logic                   f_valid,
  input  rv_core_pkg::mem_req_t  f_req,
  input  logic                   d_valid,
  input  rv_core_pkg::mem_req_t  d_req,
  output logic                   f_ready,
  output logic                   d_ready,
  output logic                   bus_valid,
  output rv_core_pkg::mem_req_t  bus_req,
  input  logic                   bus_ready,
  input  logic                   bus_rsp_valid,
  input  rv_core_pkg::mem_rsp_t  bus_rsp,
  output logic                   f_rsp_valid,
  output logic                   d_rsp_valid,
  output rv_core_pkg::mem_rsp_t  rsp
);

  logic busy, owner_d, grant_f, grant_d;

  assign grant_f = !busy && f_valid; // Fetch wins a tie
  assign grant_d = !busy && d_valid && !f_valid;
  assign bus_valid = grant_f || grant_d;
  assign bus_req = grant_d ? d_req : f_req;
  assign f_ready = grant_f && bus_ready;
  assign d_ready = grant_d && bus_ready;
  assign f_rsp_valid = bus_rsp_valid && !owner_d;
  assign d_rsp_valid = bus_rsp_valid && owner_d;
  assign rsp = bus_rsp;

  always_ff @(posedge clock) begin
    if (rst) begin
      busy <= 1'b0;
      owner_d <= 1'b0;
    end else if (bus_valid && bus_ready) begin
      busy <= 1'b1;
      owner_d <= grant_d;
    end else if (bus_rsp_valid) begin
      busy <= 1'b0;
    end
  end

  assert property (@(posedge clock) disable iff (rst) !(grant_f && grant_d));
  // Memory answers only an outstanding request
  assert property (@(posedge clock) disable iff (rst) bus_rsp_valid |-> busy);

endmodule

`default_nettype wire

//--- rv_writeback.sv
`default_nettype none

module rv_writeback (
  input  logic                          clock,
  input  logic                          rst,
  input  logic                          inst_valid,
  input  rv_core_pkg::decoded_t         dec,
  input  logic [rv_core_pkg::xlen-1:0]  alu_result,
  input  logic [rv_core_pkg::xlen-1:0]  link_addr,
  input  logic [rv_core_pkg::xlen-1:0]  load_data,
  input  logic                          lsu_done,
  output logic                          lsu_start,
  output logic                          reg_wen,
  output logic [rv_core_pkg::xlen-1:0]  reg_wdata,
  output logic                          retire,
  output logic                          halted
);
  import rv_core_pkg::*;

  typedef enum logic [1:0] {st_idle, st_exec, st_mem, st_done} wb_state_e;

  wb_state_e state;
  logic is_mem, stop;

  assign is_mem = dec.load || dec.store;
  assign stop = dec.halt || dec.illegal;
  assign lsu_start = state == st_exec && is_mem;
  assign retire = (state == st_exec && !is_mem) || (state == st_mem && lsu_done);
  assign reg_wen = retire && dec.reg_write;
  assign halted = state == st_done; // Terminal until reset

  always_comb begin
    case (dec.result_sel)
      res_mem: reg_wdata = load_data;
      res_link: reg_wdata = link_addr;
      default: reg_wdata = alu_result;
    endcase
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: if (inst_valid) state <= st_exec;
        st_exec: state <= is_mem ? st_mem : (stop ? st_done : st_idle);
        st_mem: if (lsu_done) state <= st_idle;
        default: state <= st_done;
      endcase
    end
  end

  // Fetch must not hand over another instruction once stopped
  assert property (@(posedge clock) disable iff (rst)
    halted |-> !retire && !inst_valid);

endmodule

`default_nettype wire

//--- rv_core.sv
`default_nettype none

module rv_core (
  input  logic                          clock,
  input  logic                          rst,
  output logic                          mem_req_valid,
  output rv_core_pkg::mem_req_t         mem_req,
  input  logic                          mem_req_ready,
  input  logic                          mem_rsp_valid,
  input  rv_core_pkg::mem_rsp_t         mem_rsp,
  output logic                          halted,
  output logic                          retire,
  output logic [rv_core_pkg::xlen-1:0]  retire_pc
);
  import rv_core_pkg::*;

  mem_req_t f_req, d_req;
  mem_rsp_t rsp;
  decoded_t dec;
  logic f_valid, f_ready, f_rsp_valid;
  logic d_valid, d_ready, d_rsp_valid;
  logic inst_valid, lsu_start, lsu_done, reg_wen;
  logic [xlen-1:0] inst, pc, src1, src2;
  logic [xlen-1:0] alu_result, link_addr, next_pc, load_data, reg_wdata;

  assign retire_pc = pc;

  rv_fetch u_fetch (
    .clock(clock),
    .rst(rst),
    .retire(retire),
    .next_pc(next_pc),
    .req_valid(f_valid),
    .req(f_req),
    .req_ready(f_ready),
    .rsp_valid(f_rsp_valid),
    .rsp(rsp),
    .halted(halted),
    .inst(inst),
    .pc(pc),
    .inst_valid(inst_valid)
  );

  rv_decode u_decode (
    .inst(inst),
    .dec(dec)
  );

  rv_regfile u_regfile (
    .clock(clock),
    .rst(rst),
    .raddr1(dec.rs1),
    .raddr2(dec.rs2),
    .rdata1(src1),
    .rdata2(src2),
    .wen(reg_wen),
    .waddr(dec.rd),
    .wdata(reg_wdata)
  );

  rv_execute u_execute (
    .dec(dec),
    .pc(pc),
    .src1(src1),
    .src2(src2),
    .alu_result(alu_result),
    .link_addr(link_addr),
    .branch_taken(),
    .next_pc(next_pc)
  );

  rv_lsu u_lsu (
    .clock(clock),
    .rst(rst),
    .start(lsu_start),
    .dec(dec),
    .addr(alu_result),
    .store_data(src2),
    .req_valid(d_valid),
    .req(d_req),
    .req_ready(d_ready),
    .rsp_valid(d_rsp_valid),
    .rsp(rsp),
    .load_data(load_data),
    .lsu_done(lsu_done)
  );

  rv_bus_arbiter u_arbiter (
    .clock(clock),
    .rst(rst),
    .f_valid(f_valid),
    .f_req(f_req),
    .d_valid(d_valid),
    .d_req(d_req),
    .f_ready(f_ready),
    .d_ready(d_ready),
    .bus_valid(mem_req_valid),
    .bus_req(mem_req),
    .bus_ready(mem_req_ready),
    .bus_rsp_valid(mem_rsp_valid),
    .bus_rsp(mem_rsp),
    .f_rsp_valid(f_rsp_valid),
    .d_rsp_valid(d_rsp_valid),
    .rsp(rsp)
  );

  rv_writeback u_writeback (
    .clock(clock),
    .rst(rst),
    .inst_valid(inst_valid),
    .dec(dec),
    .alu_result(alu_result),
    .link_addr(link_addr),
    .load_data(load_data),
    .lsu_done(lsu_done),
    .lsu_start(lsu_start),
    .reg_wen(reg_wen),
    .reg_wdata(reg_wdata),
    .retire(retire),
    .halted(halted)
  );

endmodule

`default_nettype wire

//--- tb_clock.sv
`default_nettype none

module tb_clock (
  output logic clock,
  output logic rst
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int half_period = 20; // 40 ns clock
  localparam int reset_cycles = 8;

  initial begin
    clock = 1'b0;
    forever #half_period clock = ~clock;
  end

  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clock);
    #1;
    rst = 1'b0; // Released just after an edge like every other input
  end

endmodule

`default_nettype wire

//--- rv_core_tb.sv
`default_nettype none

module rv_core_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import rv_core_pkg::*;

  // About 110 instructions at up to 12 cycles each, with a threefold margin
  localparam int cycle_limit = 4000;
  localparam logic [31:0] val_a = 32'hffff_fff3; // x1 = -13
  localparam logic [31:0] val_b = 32'd5;         // x2
  localparam logic [31:0] val_c = 32'h1234_5678; // x3
  localparam logic [6:0] op_imm = 7'b0010011;
  localparam logic [6:0] op_load = 7'b0000011;
  localparam logic [6:0] op_lui = 7'b0110111;
  localparam logic [6:0] op_auipc = 7'b0010111;
  localparam logic [6:0] op_jalr = 7'b1100111;

  logic clock, rst;
  logic mem_req_valid, mem_req_ready, mem_rsp_valid;
  logic halted, retire;
  logic [31:0] retire_pc;
  mem_req_t mem_req, req_n;
  mem_rsp_t mem_rsp;

  logic [31:0] mem [256];
  logic [31:0] sig_exp [64];
  string sig_name [64];
  logic [31:0] pc_w, skip_jal_pc, skip_jalr_pc, ebreak_pc;
  logic accept_n, open_req, sig_store;
  int next_slot = 0;
  int sig_seen = 0;
  int sig_errors = 0;
  int errors = 0;
  int transfers = 0;
  int stalls = 0;

  tb_clock clock_gen (
    .clock(clock),
    .rst(rst)
  );

  rv_core UUT (
    .clock(clock),
    .rst(rst),
    .mem_req_valid(mem_req_valid),
    .mem_req(mem_req),
    .mem_req_ready(mem_req_ready),
    .mem_rsp_valid(mem_rsp_valid),
    .mem_rsp(mem_rsp),
    .halted(halted),
    .retire(retire),
    .retire_pc(retire_pc)
  );

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, rs1, rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(input logic [6:0] opc, input logic [2:0] f3,
                                         input logic [4:0] rd, rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] s_type(input logic [4:0] rs2, rs1, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011}; // SW
  endfunction

  function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                         input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] u_type(input logic [6:0] opc, input logic [4:0] rd,
                                         input logic [19:0] imm);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111}; // JAL
  endfunction

  function automatic bit branch_rule(input logic [2:0] f3, input logic [31:0] a, b);
    case (f3)
      3'b000: return a == b;
      3'b001: return a != b;
      3'b100: return $signed(a) < $signed(b);
      3'b101: return $signed(a) >= $signed(b);
      3'b110: return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic emit(input logic [31:0] word);
    mem[pc_w[9:2]] = word;
    pc_w += 4;
  endtask

  // Signature slots live at 0x200, addressed through x31
  task automatic store_sig(input logic [4:0] rs, input logic [31:0] expected, input string name);
    emit(s_type(rs, 5'd31, 12'(next_slot * 4)));
    sig_exp[next_slot] = expected;
    sig_name[next_slot] = name;
    next_slot++;
  endtask

  task automatic alu_test(input logic [31:0] inst, input logic [31:0] expected,
                          input string name);
    emit(inst); // Result lands in x4
    store_sig(5'd4, expected, name);
  endtask

  task automatic branch_test(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                             input logic [31:0] a, b, input string name);
    logic [11:0] taken_mark, fall_mark;
    taken_mark = 12'h0a0 + 12'(next_slot);
    fall_mark = 12'h050 + 12'(next_slot);
    emit(b_type(f3, rs1, rs2, 13'd12)); // Taken path skips three words
    emit(i_type(op_imm, 3'b000, 5'd5, 5'd0, fall_mark));
    emit(j_type(5'd0, 21'd8));
    emit(i_type(op_imm, 3'b000, 5'd5, 5'd0, taken_mark));
    store_sig(5'd5, branch_rule(f3, a, b) ? 32'(taken_mark) : 32'(fall_mark), name);
  endtask

  task automatic flag_error(input string msg);
    errors++;
    $display("FAILED %0t: %s", $time, msg);
  endtask

  task automatic load_program;
    for (int i = 0; i < 256; i++) begin
      mem[i] = 32'hc0de_0000 | i;
    end
    pc_w = '0;
    emit(i_type(op_imm, 3'b000, 5'd31, 5'd0, 12'h200));
    emit(i_type(op_imm, 3'b000, 5'd30, 5'd0, 12'h300)); // Data area
    emit(i_type(op_imm, 3'b000, 5'd1, 5'd0, 12'hff3));
    emit(i_type(op_imm, 3'b000, 5'd2, 5'd0, 12'h005));
    emit(u_type(op_lui, 5'd3, 20'h12345));
    emit(i_type(op_imm, 3'b000, 5'd3, 5'd3, 12'h678));
    alu_test(r_type(7'h00, 3'b000, 5'd4, 5'd1, 5'd2), val_a + val_b, "add");
    alu_test(r_type(7'h20, 3'b000, 5'd4, 5'd1, 5'd2), val_a - val_b, "sub");
    alu_test(r_type(7'h00, 3'b001, 5'd4, 5'd3, 5'd2), val_c << val_b[4:0], "sll");
    alu_test(r_type(7'h00, 3'b101, 5'd4, 5'd1, 5'd2), val_a >> val_b[4:0], "srl");
    alu_test(r_type(7'h20, 3'b101, 5'd4, 5'd1, 5'd2), 32'($signed(val_a) >>> 5), "sra");
    alu_test(r_type(7'h00, 3'b010, 5'd4, 5'd1, 5'd2),
             $signed(val_a) < $signed(val_b) ? 32'd1 : 32'd0, "slt");
    alu_test(r_type(7'h00, 3'b011, 5'd4, 5'd1, 5'd2), val_a < val_b ? 32'd1 : 32'd0, "sltu");
    alu_test(r_type(7'h00, 3'b100, 5'd4, 5'd1, 5'd3), val_a ^ val_c, "xor");
    alu_test(r_type(7'h00, 3'b110, 5'd4, 5'd1, 5'd3), val_a | val_c, "or");
    alu_test(r_type(7'h00, 3'b111, 5'd4, 5'd1, 5'd3), val_a & val_c, "and");
    alu_test(i_type(op_imm, 3'b000, 5'd4, 5'd1, 12'h123), val_a + 32'h123, "addi");
    alu_test(i_type(op_imm, 3'b001, 5'd4, 5'd3, 12'h004), val_c << 4, "slli");
    alu_test(i_type(op_imm, 3'b101, 5'd4, 5'd1, 12'h403), 32'($signed(val_a) >>> 3), "srai");
    alu_test(u_type(op_lui, 5'd4, 20'habcde), 32'habcd_e000, "lui");
    alu_test(u_type(op_auipc, 5'd4, 20'h00001), pc_w + 32'h1000, "auipc");
    branch_test(3'b000, 5'd2, 5'd2, val_b, val_b, "beq equal");
    branch_test(3'b000, 5'd1, 5'd2, val_a, val_b, "beq differ");
    branch_test(3'b001, 5'd1, 5'd2, val_a, val_b, "bne differ");
    branch_test(3'b001, 5'd2, 5'd2, val_b, val_b, "bne equal");
    branch_test(3'b100, 5'd1, 5'd2, val_a, val_b, "blt neg pos");
    branch_test(3'b100, 5'd2, 5'd1, val_b, val_a, "blt pos neg");
    branch_test(3'b101, 5'd2, 5'd1, val_b, val_a, "bge pos neg");
    branch_test(3'b101, 5'd1, 5'd2, val_a, val_b, "bge neg pos");
    branch_test(3'b110, 5'd2, 5'd1, val_b, val_a, "bltu small big");
    branch_test(3'b110, 5'd1, 5'd2, val_a, val_b, "bltu big small");
    branch_test(3'b111, 5'd1, 5'd2, val_a, val_b, "bgeu big small");
    branch_test(3'b111, 5'd2, 5'd1, val_b, val_a, "bgeu small big");
    skip_jal_pc = pc_w + 4;
    emit(j_type(5'd6, 21'd8));
    emit(i_type(op_imm, 3'b000, 5'd7, 5'd0, 12'd1)); // Must never retire
    store_sig(5'd6, skip_jal_pc, "jal link");
    emit(u_type(op_auipc, 5'd8, 20'h0));
    emit(i_type(op_jalr, 3'b000, 5'd9, 5'd8, 12'd13)); // Odd target, bit 0 dropped
    skip_jalr_pc = pc_w;
    emit(i_type(op_imm, 3'b000, 5'd7, 5'd0, 12'd2));
    store_sig(5'd9, skip_jalr_pc, "jalr link");
    emit(s_type(5'd3, 5'd30, 12'h000));
    emit(i_type(op_load, 3'b010, 5'd11, 5'd30, 12'h000));
    store_sig(5'd3, val_c, "store source");
    store_sig(5'd11, val_c, "load back");
    emit(i_type(op_imm, 3'b000, 5'd0, 5'd0, 12'd77));
    emit(i_type(op_load, 3'b010, 5'd0, 5'd30, 12'h000));
    store_sig(5'd0, 32'd0, "x0 stays zero");
    ebreak_pc = pc_w;
    emit(32'h0010_0073);
  endtask

  // Inputs are stable from the falling edge to the next rising edge
  always @(negedge clock) begin
    accept_n <= !rst && mem_req_valid && mem_req_ready;
    req_n <= mem_req;
    if (!rst && mem_req_valid && mem_req_ready) transfers++;
    if (!rst && mem_req_valid && !mem_req_ready) stalls++;
  end

  always @(posedge clock) begin
    if (rst) open_req <= 1'b0;
    else if (mem_req_valid && mem_req_ready) open_req <= 1'b1;
    else if (mem_rsp_valid) open_req <= 1'b0;
  end

  initial begin : memory_model
    int unsigned wait_left;
    logic busy;
    logic [31:0] rdata;
    void'($urandom(32'h1f00_13dd));
    mem_req_ready = 1'b0;
    mem_rsp_valid = 1'b0;
    mem_rsp = '0;
    busy = 1'b0;
    wait_left = 0;
    rdata = '0;
    forever begin
      @(posedge clock);
      #1;
      mem_rsp_valid = 1'b0;
      if (rst) begin
        busy = 1'b0;
        mem_req_ready = 1'b0;
      end else begin
        if (accept_n) begin // Request taken at this edge
          rdata = req_n.write ? '0 : mem[req_n.addr[9:2]];
          if (req_n.write) mem[req_n.addr[9:2]] = req_n.wdata;
          if (req_n.write && req_n.addr[31:8] == 24'h2) begin
            sig_seen++;
            $display("%s: stored 0x%08h", sig_name[req_n.addr[7:2]], req_n.wdata);
          end
          busy = 1'b1;
          wait_left = $urandom_range(3, 0);
        end
        if (busy && wait_left == 0) begin
          mem_rsp_valid = 1'b1;
          mem_rsp = '{rdata: rdata, err: 1'b0};
          busy = 1'b0;
        end else if (busy) begin
          wait_left--;
        end
        mem_req_ready = $urandom_range(3, 0) != 0; // Low about one cycle in four
      end
    end
  end

  assign sig_store = mem_req_valid && mem_req_ready && mem_req.write &&
                     mem_req.addr[31:8] == 24'h2;

  assert property (@(posedge clock) disable iff (rst)
    sig_store |-> mem_req.wdata == sig_exp[mem_req.addr[7:2]])
    else begin
      sig_errors++;
      flag_error($sformatf("%s stored 0x%08h, expected 0x%08h", sig_name[req_n.addr[7:2]],
                           req_n.wdata, sig_exp[req_n.addr[7:2]]));
    end

  assert property (@(posedge clock) disable iff (rst)
    mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
    else flag_error("a stalled request changed or was withdrawn");

  // Word stores write all four bytes
  assert property (@(posedge clock) disable iff (rst)
    mem_req_valid && mem_req.write |-> mem_req.strb == 4'hf)
    else flag_error("a store request did not set all four byte strobes");

  assert property (@(posedge clock) disable iff (rst) open_req |-> !mem_req_valid)
    else flag_error("a new request was issued before the previous response");

  assert property (@(posedge clock) disable iff (rst)
    retire |-> retire_pc != skip_jal_pc && retire_pc != skip_jalr_pc)
    else flag_error("an instruction skipped by a jump retired");

  assert property (@(posedge clock) disable iff (rst) retire && retire_pc == ebreak_pc |=> halted)
    else flag_error("halted did not rise one cycle after EBREAK retired");

  assert property (@(posedge clock) disable iff (rst) $rose(halted) |-> $past(retire))
    else flag_error("halted rose without a retire in the cycle before");

  assert property (@(posedge clock) disable iff (rst) halted |-> !mem_req_valid && !retire)
    else flag_error("the core issued a request or retired after halting");

  assert property (@(posedge clock) rst |=> !mem_req_valid && !retire && !halted)
    else flag_error("request, retire or halted was high during reset");

  initial begin : control
    int cycles;
    load_program();
    @(negedge rst);
    cycles = 0;
    while (!halted && cycles < cycle_limit) begin
      @(negedge clock);
      cycles++;
    end
    if (!halted) begin
      $display("Timeout: the core did not halt within %0d cycles", cycle_limit);
      $display("STATUS: FAIL");
    end else begin
      repeat (20) @(posedge clock); // Bus must stay quiet after the halt
      @(negedge clock);
      if (sig_seen != next_slot)
        flag_error($sformatf("only %0d of %0d signatures were written", sig_seen, next_slot));
      $display("halt: halted after EBREAK at 0x%08h in %0d cycles", ebreak_pc, cycles);
      $display("back-pressure: %0d transfers, %0d stalled cycles", transfers, stalls);
      $display("Checks passed: %0d, failed: %0d", sig_seen - sig_errors, errors);
      if (errors == 0) begin
        $display("STATUS: PASS");
      end else begin
        $display("STATUS: FAIL");
      end
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- rv_core.f
rv_core_pkg.sv
rv_fetch.sv
rv_decode.sv
rv_regfile.sv
rv_execute.sv
rv_lsu.sv
rv_bus_arbiter.sv
rv_writeback.sv
rv_core.sv
tb_clock.sv
rv_core_tb.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - rv_core_pkg.sv
  - rv_fetch.sv
  - rv_decode.sv
  - rv_regfile.sv
  - rv_execute.sv
  - rv_lsu.sv
  - rv_bus_arbiter.sv
  - rv_writeback.sv
  - rv_core.sv
  - target: test
    files:
      - tb_clock.sv
      - rv_core_tb.sv
